/* sigmoid.f */
design/sigmoidPkg.sv
design/segmentLookup.sv
design/slopeMultiplier.sv
design/outputStage.sv
design/sigmoidTop.sv
testbench/sigmoid_assert.sv
testbench/tb_sigmoid.sv

/* Bender.yml */
package:
  name: sigmoid

sources:
  - files:
      - design/sigmoidPkg.sv
      - design/segmentLookup.sv
      - design/slopeMultiplier.sv
      - design/outputStage.sv
      - design/sigmoidTop.sv
  - target: test
    files:
      - testbench/sigmoid_assert.sv
      - testbench/tb_sigmoid.sv

/* testbench/tb_sigmoid.sv */
`default_nettype none

module tb_sigmoid;

	localparam int ClkPeriod = 4;
	localparam int ResetCycles = 10;
	localparam int Seed = 12583;
	localparam int SweepCount = 256;
	localparam int RandomCount = 300;
	localparam int EdgeCount = 10;
	localparam int FillCount = 4;
	localparam int IdleGap = 8;
	localparam int LatencyWindow = sigmoidPkg::PipeLatency + 4;
	localparam int DrainLimit = sigmoidPkg::PipeLatency + 4;

	// Worst case cycle count of every test together
	localparam int StimCycles = ResetCycles
		+ (SweepCount + DrainLimit)
		+ (IdleGap + LatencyWindow + 1 + DrainLimit)
		+ (2 * RandomCount + DrainLimit)
		+ (EdgeCount + DrainLimit)
		+ (FillCount + 1 + ResetCycles + IdleGap + LatencyWindow + 1 + DrainLimit);

	// Segment edges at magnitudes 15, 16, 127 and 128 with both signs
	localparam logic [7:0] EdgeValues [EdgeCount] = '{
		8'h00, 8'h01, 8'hFF, 8'h0F, 8'hF1,
		8'h10, 8'hF0, 8'h7F, 8'h81, 8'h80
	};

	logic clk;
	logic rstN;
	logic inValid;
	logic [sigmoidPkg::InWidth-1:0] xIn;
	logic [sigmoidPkg::OutWidth-1:0] yOut;
	logic outValid;

	// Expected outputs in input order
	logic [sigmoidPkg::OutWidth-1:0] expQ [$];
	logic [sigmoidPkg::OutWidth-1:0] expected;

	int errorCount = 0;
	int checkCount = 0;
	int outCount = 0;
	int testErrStart;
	int testChkStart;

	sigmoidTop sigmoidTop_inst (
		.clk        (clk),
		.i_rstN     (rstN),
		.i_inValid  (inValid),
		.i_x        (xIn),
		.o_y        (yOut),
		.o_outValid (outValid)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// Piecewise-linear sigmoid worked out from x alone
	function automatic logic [sigmoidPkg::OutWidth-1:0] refSigmoid(input logic [7:0] x);
		logic neg;
		logic [7:0] mag;
		int seg;
		int funcInt;
		logic [11:0] intercept;
		logic [11:0] funcVal;
		logic [10:0] high;
		logic [3:0] low;
		neg = x[7];
		mag = x;
		if (neg) begin
			mag = 8'd0 - x;
		end
		seg = mag[7] ? 7 : int'(mag[6:4]);
		intercept = {2'b01, sigmoidPkg::IntcptTable[seg]};
		funcInt = int'(mag) * int'(sigmoidPkg::SlopeTable[seg]) + int'(intercept);
		// Keep only the low 12 bits
		funcVal = 12'(funcInt);
		high = funcVal[10:0];
		low = 4'b0011;
		if (neg) begin
			high = ~high;
			low = 4'b1011;
		end
		return {1'b0, high, low};
	endfunction

	// Checks each output against the head of the queue
	always @(negedge clk) begin
		if (outValid === 1'b1) begin
			checkCount++;
			outCount++;
			assert (expQ.size() != 0) else begin
				errorCount++;
				$display("ERROR at %0t: output valid while no input was pending", $time);
			end
			if (expQ.size() != 0) begin
				expected = expQ.pop_front();
				assert (yOut === expected) else begin
					errorCount++;
					$display("FAIL time=%0t signal=o_y expected=%h actual=%h",
						$time, expected, yOut);
				end
			end
		end
	end

	task automatic sendValue(input logic [7:0] x);
		@(negedge clk);
		inValid = 1'b1;
		xIn = x;
		expQ.push_back(refSigmoid(x));
	endtask

	task automatic idleCycle();
		@(negedge clk);
		inValid = 1'b0;
		xIn = 8'($urandom);
	endtask

	// Waits a bounded time for pending outputs
	task automatic drainPipe();
		int waited;
		waited = 0;
		while (expQ.size() != 0 && waited < DrainLimit) begin
			idleCycle();
			waited++;
		end
		checkCount++;
		assert (expQ.size() == 0) else begin
			errorCount++;
			$display("ERROR at %0t: %0d expected outputs never appeared", $time, expQ.size());
		end
	endtask

	// One valid input gives o_outValid high on exactly one later edge
	task automatic checkLatency(input logic [7:0] x);
		logic due;
		sendValue(x);
		for (int cycle = 1; cycle <= LatencyWindow; cycle++) begin
			@(negedge clk);
			inValid = 1'b0;
			due = (cycle == sigmoidPkg::PipeLatency);
			checkCount++;
			assert (outValid === due) else begin
				errorCount++;
				$display("FAIL time=%0t signal=o_outValid expected=%b actual=%b",
					$time, due, outValid);
			end
		end
	endtask

	task automatic checkIdle(input int cycles);
		for (int k = 0; k < cycles; k++) begin
			idleCycle();
			checkCount++;
			assert (outValid === 1'b0) else begin
				errorCount++;
				$display("ERROR at %0t: output valid without any input since reset", $time);
			end
		end
	endtask

	task automatic startTest();
		testErrStart = errorCount;
		testChkStart = checkCount;
	endtask

	task automatic endTest(input string name);
		$display("Test %s: %0d checks, %0d errors", name,
			checkCount - testChkStart, errorCount - testErrStart);
	endtask

	task automatic randomGaps();
		int sent;
		int idles;
		int startOut;
		sent = 0;
		idles = 0;
		startOut = outCount;
		// Roughly one idle cycle in three
		while (sent < RandomCount) begin
			if (($urandom % 3) == 0 && idles < RandomCount) begin
				idleCycle();
				idles++;
			end else begin
				sendValue(8'($urandom));
				sent++;
			end
		end
		drainPipe();
		checkCount++;
		assert (outCount - startOut == RandomCount) else begin
			errorCount++;
			$display("ERROR at %0t: %0d outputs seen for %0d inputs sent",
				$time, outCount - startOut, RandomCount);
		end
	endtask

	task automatic midReset();
		for (int k = 0; k < FillCount; k++) begin
			sendValue(8'($urandom));
		end
		@(negedge clk);
		inValid = 1'b0;
		// Reset with four items in flight
		rstN = 1'b0;
		expQ.delete();
		checkIdle(ResetCycles);
		rstN = 1'b1;
		checkIdle(IdleGap);
		checkLatency(8'h9C);
		drainPipe();
	endtask

	initial begin
		rstN = 1'b0;
		inValid = 1'b0;
		xIn = '0;
		void'($urandom(Seed));
		repeat (ResetCycles) @(negedge clk);
		rstN = 1'b1;

		startTest();
		for (int v = 0; v < SweepCount; v++) begin
			sendValue(8'(v));
		end
		drainPipe();
		endTest("exhaustive sweep");

		startTest();
		repeat (IdleGap) idleCycle();
		checkLatency(8'h35);
		drainPipe();
		endTest("exact latency");

		startTest();
		randomGaps();
		endTest("random gaps");

		startTest();
		for (int k = 0; k < EdgeCount; k++) begin
			sendValue(EdgeValues[k]);
		end
		drainPipe();
		endTest("boundaries");

		startTest();
		midReset();
		endTest("mid-stream reset");

		checkCount++;
		assert (expQ.size() == 0) else begin
			errorCount++;
			$display("ERROR: %0d expected outputs left over at the end", expQ.size());
		end
		$display("Checks %0d, errors %0d, outputs %0d", checkCount, errorCount, outCount);
		if (errorCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#((StimCycles + sigmoidPkg::PipeLatency + 20) * ClkPeriod);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/sigmoid_assert.sv */
`default_nettype none

module sigmoid_assert (
	input wire logic clk,
	input wire logic i_rstN,
	input wire logic i_inValid,
	input wire logic i_outValid,
	input wire logic [sigmoidPkg::OutWidth-1:0] i_y
);

	// Cycles since reset release, saturating at the latency
	logic [3:0] sinceReset;

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			sinceReset <= '0;
		end else if (sinceReset < sigmoidPkg::PipeLatency) begin
			sinceReset <= sinceReset + 4'd1;
		end
	end

	// Valid comes out exactly one pipeline depth later
	validDelay: assert property (@(posedge clk) disable iff (!i_rstN)
		(sinceReset == sigmoidPkg::PipeLatency) |->
			(i_outValid == $past(i_inValid, sigmoidPkg::PipeLatency)))
		else $error("o_outValid does not follow i_inValid by the pipeline latency");

	topBitZero: assert property (@(posedge clk) i_y[sigmoidPkg::OutWidth-1] == 1'b0)
		else $error("o_y top bit is set");

	validKnown: assert property (@(posedge clk) !$isunknown(i_outValid))
		else $error("o_outValid is unknown");

endmodule

bind sigmoidTop sigmoid_assert sigmoidAssert_inst (
	.clk        (clk),
	.i_rstN     (i_rstN),
	.i_inValid  (i_inValid),
	.i_outValid (o_outValid),
	.i_y        (o_y)
);

`default_nettype wire

/* design/sigmoidTop.sv */
`default_nettype none

module sigmoidTop (
	input  logic clk,
	input  logic i_rstN,
	input  logic i_inValid,
	input  logic [sigmoidPkg::InWidth-1:0] i_x,
	output logic [sigmoidPkg::OutWidth-1:0] o_y,
	output logic o_outValid
);

	// Section boundaries, each struct carries its own valid
	sigmoidPkg::lookup_t lookupStage;
	sigmoidPkg::product_t productStage;

	// Stages 0 and 1
	// Sign, magnitude and table lookup
	segmentLookup segmentLookup_inst (
		.clk       (clk),
		.i_rstN    (i_rstN),
		.i_inValid (i_inValid),
		.i_x       (i_x),
		.o_stage   (lookupStage)
	);

	// Stages 2 and 3
	// Magnitude times slope
	slopeMultiplier slopeMultiplier_inst (
		.clk     (clk),
		.i_rstN  (i_rstN),
		.i_stage (lookupStage),
		.o_stage (productStage)
	);

	// Stages 4 and 5
	// Intercept add and sign fold
	outputStage outputStage_inst (
		.clk        (clk),
		.i_rstN     (i_rstN),
		.i_stage    (productStage),
		.o_y        (o_y),
		.o_outValid (o_outValid)
	);

endmodule

`default_nettype wire

/* design/outputStage.sv */
`default_nettype none

module outputStage (
	input  logic clk,
	input  logic i_rstN,
	input  sigmoidPkg::product_t i_stage,
	output logic [sigmoidPkg::OutWidth-1:0] o_y,
	output logic o_outValid
);

	// Low nibble constants for the two signs
	localparam logic [3:0] NegNibble = 4'b1011;
	localparam logic [3:0] PosNibble = 4'b0011;

	// Stage 4 result
	logic [sigmoidPkg::FuncWidth-1:0] funcSum;

	// Stage 4 register
	logic s4Valid;
	logic s4Sign;
	logic [sigmoidPkg::FuncWidth-1:0] s4Sum;

	// Stage 5 value before the register
	logic [sigmoidPkg::OutWidth-2:0] yNext;
	logic [sigmoidPkg::OutWidth-2:0] yReg;

	// Wraps modulo 4096
	assign funcSum = i_stage.product + i_stage.intercept;

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			s4Valid <= 1'b0;
			s4Sign <= 1'b0;
			s4Sum <= '0;
		end else begin
			s4Valid <= i_stage.valid;
			s4Sign <= i_stage.sign;
			s4Sum <= funcSum;
		end
	end

	// Negative inputs give 1 - f(|x|), done as a bitwise complement
	always_comb begin
		yNext[sigmoidPkg::OutWidth-2:4] =
			s4Sum[sigmoidPkg::FuncWidth-2:0] ^ {(sigmoidPkg::FuncWidth-1){s4Sign}};
		if (s4Sign) begin
			yNext[3:0] = NegNibble;
		end else begin
			yNext[3:0] = PosNibble;
		end
	end

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_outValid <= 1'b0;
			yReg <= '0;
		end else begin
			o_outValid <= s4Valid;
			yReg <= yNext;
		end
	end

	// Top bit is always zero
	assign o_y = {1'b0, yReg};

endmodule

`default_nettype wire

/* design/slopeMultiplier.sv */
`default_nettype none

module slopeMultiplier (
	input  logic clk,
	input  logic i_rstN,
	input  sigmoidPkg::lookup_t i_stage,
	output sigmoidPkg::product_t o_stage
);

	// Magnitude gated by each slope bit
	logic [sigmoidPkg::MagWidth-1:0] partialProd [sigmoidPkg::SlopeWidth];

	// Stage 2 sums
	logic [sigmoidPkg::SumWidth-1:0] sumLow;
	logic [sigmoidPkg::SumWidth-1:0] sumHigh;

	// Stage 2 register
	sigmoidPkg::partial_t s2Stage;

	// Stage 3 full product
	logic [sigmoidPkg::FuncWidth-1:0] product;

	// Adds a pair of partial products, the second one weighted by two
	function automatic logic [sigmoidPkg::SumWidth-1:0] pairSum(
		input logic [sigmoidPkg::MagWidth-1:0] lowTerm,
		input logic [sigmoidPkg::MagWidth-1:0] highTerm
	);
		logic [sigmoidPkg::SumWidth-1:0] lowExt;
		logic [sigmoidPkg::SumWidth-1:0] highExt;
		lowExt = {2'b00, lowTerm};
		highExt = {1'b0, highTerm, 1'b0};
		return lowExt + highExt;
	endfunction

	always_comb begin
		for (int k = 0; k < sigmoidPkg::SlopeWidth; k++) begin
			partialProd[k] = i_stage.magnitude & {sigmoidPkg::MagWidth{i_stage.slope[k]}};
		end
	end

	// Bits 0,1 and bits 2,3 of the slope
	assign sumLow = pairSum(partialProd[0], partialProd[1]);
	assign sumHigh = pairSum(partialProd[2], partialProd[3]);

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			s2Stage <= '0;
		end else begin
			s2Stage.valid <= i_stage.valid;
			s2Stage.sign <= i_stage.sign;
			s2Stage.sumLow <= sumLow;
			s2Stage.sumHigh <= sumHigh;
			s2Stage.intercept <= i_stage.intercept;
		end
	end

	// High pair weighs four times the low pair
	// 255 x 15 stays below 4096 so nothing is lost
	assign product = {2'b00, s2Stage.sumLow} + {s2Stage.sumHigh, 2'b00};

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_stage <= '0;
		end else begin
			o_stage.valid <= s2Stage.valid;
			o_stage.sign <= s2Stage.sign;
			o_stage.product <= product;
			o_stage.intercept <= s2Stage.intercept;
		end
	end

endmodule

`default_nettype wire

/* design/segmentLookup.sv */
`default_nettype none

module segmentLookup (
	input  logic clk,
	input  logic i_rstN,
	input  logic i_inValid,
	input  logic [sigmoidPkg::InWidth-1:0] i_x,
	output sigmoidPkg::lookup_t o_stage
);

	// Stage 0 outputs
	logic s0Valid;
	logic s0Sign;
	logic [sigmoidPkg::MagWidth-1:0] s0Mag;

	// Stage 0 next values
	logic inSign;
	logic [sigmoidPkg::MagWidth-1:0] inMag;

	// Stage 1 lookup
	sigmoidPkg::segment_e segment;
	logic [sigmoidPkg::SlopeWidth-1:0] slope;
	logic [sigmoidPkg::IntcptWidth-1:0] intercept;

	// Sign bit straight from the input
	assign inSign = i_x[sigmoidPkg::InWidth-1];

	// Two's complement negate, -128 wraps to 128
	always_comb begin
		if (inSign) begin
			inMag = ~i_x + 8'd1;
		end else begin
			inMag = i_x;
		end
	end

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			s0Valid <= 1'b0;
			s0Sign <= 1'b0;
			s0Mag <= '0;
		end else begin
			s0Valid <= i_inValid;
			s0Sign <= inSign;
			s0Mag <= inMag;
		end
	end

	// Segments are 16 wide up to 127, one segment above that
	always_comb begin
		if (s0Mag[sigmoidPkg::MagWidth-1]) begin
			segment = sigmoidPkg::SEG7;
		end else begin
			segment = sigmoidPkg::segment_e'(s0Mag[6:4]);
		end
	end

	// Table lookup
	always_comb begin
		slope = sigmoidPkg::SlopeTable[segment];
		intercept = {sigmoidPkg::IntcptLead, sigmoidPkg::IntcptTable[segment]};
	end

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_stage <= '0;
		end else begin
			o_stage.valid <= s0Valid;
			o_stage.sign <= s0Sign;
			o_stage.magnitude <= s0Mag;
			o_stage.slope <= slope;
			o_stage.intercept <= intercept;
		end
	end

endmodule

`default_nettype wire

/* design/sigmoidPkg.sv */
`default_nettype none

package sigmoidPkg;

	// Datapath widths
	localparam int InWidth = 8;
	localparam int MagWidth = 8;
	localparam int SlopeWidth = 4;
	localparam int IntcptWidth = 12;
	localparam int FuncWidth = 12;
	localparam int OutWidth = 16;

	// Pair of partial products, one of them shifted by one
	localparam int SumWidth = MagWidth + 2;

	// Intercept is 01 followed by a 10-bit fraction
	localparam int IntcptFracWidth = IntcptWidth - 2;
	localparam logic [1:0] IntcptLead = 2'b01;

	// Input to output, in clock cycles
	localparam int PipeLatency = 6;

	// SEG7 catches every magnitude of 128 and above
	typedef enum logic [2:0] {
		SEG0,
		SEG1,
		SEG2,
		SEG3,
		SEG4,
		SEG5,
		SEG6,
		SEG7
	} segment_e;

	// Slope per segment, scaled by 2^-6
	localparam logic [SlopeWidth-1:0] SlopeTable [8] = '{
		4'b1111, 4'b1110, 4'b1011, 4'b1000,
		4'b0110, 4'b0100, 4'b0010, 4'b0001
	};

	// Intercept fraction per segment
	localparam logic [IntcptFracWidth-1:0] IntcptTable [8] = '{
		10'b00_0000_0011, 10'b00_0001_1101, 10'b00_0111_1110, 10'b01_0000_1111,
		10'b01_1000_1011, 10'b10_0010_0100, 10'b10_1110_0010, 10'b11_0101_1000
	};

	// Stage 1 to stage 2
	typedef struct packed {
		logic valid;
		logic sign;
		logic [MagWidth-1:0] magnitude;
		logic [SlopeWidth-1:0] slope;
		logic [IntcptWidth-1:0] intercept;
	} lookup_t;

	// Stage 2 to stage 3, two half sums of the product
	typedef struct packed {
		logic valid;
		logic sign;
		logic [SumWidth-1:0] sumLow;
		logic [SumWidth-1:0] sumHigh;
		logic [IntcptWidth-1:0] intercept;
	} partial_t;

	// Stage 3 to stage 4
	typedef struct packed {
		logic valid;
		logic sign;
		logic [FuncWidth-1:0] product;
		logic [IntcptWidth-1:0] intercept;
	} product_t;

endpackage

`default_nettype wire
